// ==== source/ex_cfg.svh ====
`ifndef EX_CFG_SVH
`define EX_CFG_SVH

// operand and result width
`define EX_DATA_W 32
// register file address width
`define EX_REGADDR_W 6
// redundant alu lanes
`define EX_NUM_LANES 3
// mismatches before a lane is retired for good
`define EX_FAULT_THRESH 4
`define EX_FAULT_CNT_W 3

`endif

// ==== source/ex_dp_pkg.sv ====
`default_nettype none

package ex_dp_pkg;

  `include "ex_cfg.svh"

  // one alu operand or result word
  typedef logic [`EX_DATA_W-1:0] data_t;
  // register file destination
  typedef logic [`EX_REGADDR_W-1:0] regaddr_t;

  // alu operations kept in this stage
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SLTU = 4'd7,
    ALU_EQ   = 4'd8
  } alu_op_e;

endpackage

`default_nettype wire

// ==== source/ex_ft_pkg.sv ====
`default_nettype none

package ex_ft_pkg;

  `include "ex_cfg.svh"

  // one bit per redundant lane
  typedef logic [`EX_NUM_LANES-1:0] lane_mask_t;
  // per-lane mismatch count
  typedef logic [`EX_FAULT_CNT_W-1:0] fault_cnt_t;

  // voting scheme, picked by the number of retired lanes
  typedef enum logic [1:0] {VOTE_THREE = 2'd0, VOTE_TWO = 2'd1, VOTE_BYPASS = 2'd2} vote_mode_e;

endpackage

`default_nettype wire

// ==== source/alu_result_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// voted alu outcome plus fault status
interface alu_result_if import ex_dp_pkg::*; import ex_ft_pkg::*; ();

  data_t      result;
  logic       cmp_result;
  logic       err_detected;
  logic       err_corrected;
  lane_mask_t faulty_lanes;

  // voter side
  modport producer (output result, cmp_result, err_detected, err_corrected, faulty_lanes);

  // write port side, only the data path
  modport consumer (input result, cmp_result);

endinterface

`default_nettype wire

// ==== source/ex_alu_lane.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_alu_lane import ex_dp_pkg::*; (
  input  alu_op_e operator_i,
  input  data_t   operand_a_i,
  input  data_t   operand_b_i,
  output data_t   result_o,
  output logic    cmp_o
);

  always_comb begin
    result_o = '0;
    cmp_o    = 1'b0;
    case (operator_i)
      ALU_ADD: result_o = operand_a_i + operand_b_i;
      ALU_SUB: result_o = operand_a_i - operand_b_i;
      ALU_AND: result_o = operand_a_i & operand_b_i;
      ALU_OR:  result_o = operand_a_i | operand_b_i;
      ALU_XOR: result_o = operand_a_i ^ operand_b_i;
      // shift amount is the low five bits of b
      ALU_SLL: result_o = operand_a_i << operand_b_i[4:0];
      ALU_SRL: result_o = operand_a_i >> operand_b_i[4:0];
      // compares also show up zero-extended on the result
      ALU_SLTU: begin
        cmp_o    = operand_a_i < operand_b_i;
        result_o = data_t'(cmp_o);
      end
      ALU_EQ: begin
        cmp_o    = operand_a_i == operand_b_i;
        result_o = data_t'(cmp_o);
      end
      // unused encodings give zero
      default: result_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== source/ex_tmr_voter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ex_cfg.svh"

module ex_tmr_voter import ex_dp_pkg::*; import ex_ft_pkg::*; (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           alu_en_i,
  input  data_t [`EX_NUM_LANES-1:0]      lane_result_i,
  input  lane_mask_t                     lane_cmp_i,
  alu_result_if.producer                 res
);

  localparam int NF_W  = $clog2(`EX_NUM_LANES + 1);
  localparam int SEL_W = $clog2(`EX_NUM_LANES);

  fault_cnt_t       cnt_q [`EX_NUM_LANES];
  lane_mask_t       faulty;
  lane_mask_t       odd_lane;
  logic [NF_W-1:0]  n_faulty;
  logic [SEL_W-1:0] sel;
  logic             det;
  logic             corr;
  logic             eq01;
  logic             eq02;
  logic             eq12;
  vote_mode_e       mode;

  //////////////////////////////
  // lane agreement and mode
  //////////////////////////////

  // a pair agrees only if result and compare bit both match
  assign eq01 = (lane_result_i[0] == lane_result_i[1]) && (lane_cmp_i[0] == lane_cmp_i[1]);
  assign eq02 = (lane_result_i[0] == lane_result_i[2]) && (lane_cmp_i[0] == lane_cmp_i[2]);
  assign eq12 = (lane_result_i[1] == lane_result_i[2]) && (lane_cmp_i[1] == lane_cmp_i[2]);

  always_comb begin
    n_faulty = '0;
    for (int i = 0; i < `EX_NUM_LANES; i++) begin
      // counter pinned at threshold marks the lane dead
      faulty[i] = cnt_q[i] == fault_cnt_t'(`EX_FAULT_THRESH);
      if (faulty[i]) n_faulty = n_faulty + NF_W'(1);
    end
    if (n_faulty == '0) mode = VOTE_THREE;
    else if (n_faulty == NF_W'(1)) mode = VOTE_TWO;
    else mode = VOTE_BYPASS;
  end

  //////////////////////////////
  // vote
  //////////////////////////////

  always_comb begin
    sel      = '0;
    det      = 1'b0;
    corr     = 1'b0;
    odd_lane = '0;
    case (mode)
      VOTE_THREE: begin
        if (eq01 && eq02) begin
          sel = '0;
        end else if (eq01) begin
          // lane 2 outvoted
          det = 1'b1;
          corr = 1'b1;
          odd_lane = 3'b100;
        end else if (eq02) begin
          det = 1'b1;
          corr = 1'b1;
          odd_lane = 3'b010;
        end else if (eq12) begin
          sel = SEL_W'(1);
          det = 1'b1;
          corr = 1'b1;
          odd_lane = 3'b001;
        end else begin
          // no majority, fall back on lane 0
          det = 1'b1;
        end
      end
      VOTE_TWO: begin
        // compare the two survivors, lower index wins on a mismatch
        case (faulty)
          3'b001: begin
            sel = SEL_W'(1);
            det = !eq12;
          end
          3'b010:  det = !eq02;
          default: det = !eq01;
        endcase
      end
      default: begin
        // first healthy lane, lane 0 if none is left
        for (int i = `EX_NUM_LANES - 1; i >= 0; i--) begin
          if (!faulty[i]) sel = SEL_W'(i);
        end
      end
    endcase
  end

  assign res.result        = lane_result_i[sel];
  assign res.cmp_result    = lane_cmp_i[sel];
  assign res.err_detected  = alu_en_i & det;
  assign res.err_corrected = alu_en_i & corr;
  assign res.faulty_lanes  = faulty;

  //////////////////////////////
  // mismatch counters
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `EX_NUM_LANES; i++) cnt_q[i] <= '0;
    end else begin
      for (int i = 0; i < `EX_NUM_LANES; i++) begin
        // only a lone outvoted lane counts, stop at threshold
        if (alu_en_i && mode == VOTE_THREE && odd_lane[i] && !faulty[i]) begin
          cnt_q[i] <= cnt_q[i] + fault_cnt_t'(1);
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/ex_wb_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_wb_reg import ex_dp_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     alu_en_i,
  input  logic     csr_access_i,
  input  logic     lsu_en_i,
  input  logic     branch_in_ex_i,
  input  logic     lsu_ready_ex_i,
  input  logic     wb_ready_i,
  input  logic     regfile_we_i,
  input  regaddr_t regfile_waddr_i,
  input  logic     lsu_err_i,
  output logic     wb_we_o,
  output regaddr_t wb_waddr_o,
  output logic     ex_ready_o,
  output logic     ex_valid_o
);

  logic     we_q;
  regaddr_t waddr_q;
  logic     load_ok;

  // branches retire here, so ready ignores the back end for them
  assign ex_ready_o = (lsu_ready_ex_i & wb_ready_i) | branch_in_ex_i;
  assign ex_valid_o = (alu_en_i | csr_access_i | lsu_en_i) & lsu_ready_ex_i & wb_ready_i;

  // a faulting access never reaches the register file
  assign load_ok = regfile_we_i & ~lsu_err_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      we_q <= 1'b0;
    end else if (ex_valid_o) begin
      we_q <= load_ok;
    end else if (wb_ready_i) begin
      // wb idle and nothing new, drop the entry
      we_q <= 1'b0;
    end
  end

  // destination only matters while we_q is set
  always_ff @(posedge clk) begin
    if (ex_valid_o && load_ok) waddr_q <= regfile_waddr_i;
  end

  assign wb_we_o    = we_q;
  assign wb_waddr_o = waddr_q;

endmodule

`default_nettype wire

// ==== source/ex_wb_ports.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_wb_ports import ex_dp_pkg::*; (
  alu_result_if.consumer res,
  input  logic           regfile_alu_we_i,
  input  regaddr_t       regfile_alu_waddr_i,
  input  logic           csr_access_i,
  input  data_t          csr_rdata_i,
  input  logic           wb_we_i,
  input  regaddr_t       wb_waddr_i,
  input  data_t          lsu_rdata_i,
  output logic           regfile_alu_we_fw_o,
  output regaddr_t       regfile_alu_waddr_fw_o,
  output data_t          regfile_alu_wdata_fw_o,
  output logic           regfile_we_wb_o,
  output regaddr_t       regfile_waddr_wb_o,
  output data_t          regfile_wdata_wb_o,
  output logic           branch_decision_o
);

  // alu/csr forwarding port, csr read data takes priority
  assign regfile_alu_we_fw_o    = regfile_alu_we_i;
  assign regfile_alu_waddr_fw_o = regfile_alu_waddr_i;
  assign regfile_alu_wdata_fw_o = csr_access_i ? csr_rdata_i : res.result;

  // load/store port, buffered destination with memory data
  assign regfile_we_wb_o    = wb_we_i;
  assign regfile_waddr_wb_o = wb_waddr_i;
  assign regfile_wdata_wb_o = lsu_rdata_i;

  // branch taken straight from the voted compare
  assign branch_decision_o = res.cmp_result;

endmodule

`default_nettype wire

// ==== source/ex_stage_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_stage_top import ex_dp_pkg::*; import ex_ft_pkg::*; (
  input  logic                               clk,
  input  logic                               rst_n,
  input  alu_op_e [$bits(lane_mask_t)-1:0]   alu_operator_i,
  input  data_t   [$bits(lane_mask_t)-1:0]   alu_operand_a_i,
  input  data_t   [$bits(lane_mask_t)-1:0]   alu_operand_b_i,
  input  logic                               alu_en_i,
  input  logic                               csr_access_i,
  input  data_t                              csr_rdata_i,
  input  logic                               lsu_en_i,
  input  data_t                              lsu_rdata_i,
  input  logic                               lsu_ready_ex_i,
  input  logic                               lsu_err_i,
  input  logic                               branch_in_ex_i,
  input  logic                               wb_ready_i,
  input  logic                               regfile_alu_we_i,
  input  regaddr_t                           regfile_alu_waddr_i,
  input  logic                               regfile_we_i,
  input  regaddr_t                           regfile_waddr_i,
  output logic                               regfile_alu_we_fw_o,
  output regaddr_t                           regfile_alu_waddr_fw_o,
  output data_t                              regfile_alu_wdata_fw_o,
  output logic                               regfile_we_wb_o,
  output regaddr_t                           regfile_waddr_wb_o,
  output data_t                              regfile_wdata_wb_o,
  output logic                               branch_decision_o,
  output logic                               ex_ready_o,
  output logic                               ex_valid_o,
  output logic                               err_detected_o,
  output logic                               err_corrected_o,
  output lane_mask_t                         permanent_faulty_o
);

  localparam int NUM_LANES = $bits(lane_mask_t);

  data_t [NUM_LANES-1:0] lane_result;
  lane_mask_t            lane_cmp;
  logic                  wb_we;
  regaddr_t              wb_waddr;

  alu_result_if res_if ();

  //////////////////////////////
  // redundant lanes
  //////////////////////////////

  // each lane sees its own decoded copy
  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    ex_alu_lane u_lane (
      .operator_i  (alu_operator_i[i]),
      .operand_a_i (alu_operand_a_i[i]),
      .operand_b_i (alu_operand_b_i[i]),
      .result_o    (lane_result[i]),
      .cmp_o       (lane_cmp[i])
    );
  end

  ex_tmr_voter u_voter (
    .clk           (clk),
    .rst_n         (rst_n),
    .alu_en_i      (alu_en_i),
    .lane_result_i (lane_result),
    .lane_cmp_i    (lane_cmp),
    .res           (res_if.producer)
  );

  //////////////////////////////
  // pipeline and write ports
  //////////////////////////////

  ex_wb_reg u_wb_reg (
    .clk             (clk),
    .rst_n           (rst_n),
    .alu_en_i        (alu_en_i),
    .csr_access_i    (csr_access_i),
    .lsu_en_i        (lsu_en_i),
    .branch_in_ex_i  (branch_in_ex_i),
    .lsu_ready_ex_i  (lsu_ready_ex_i),
    .wb_ready_i      (wb_ready_i),
    .regfile_we_i    (regfile_we_i),
    .regfile_waddr_i (regfile_waddr_i),
    .lsu_err_i       (lsu_err_i),
    .wb_we_o         (wb_we),
    .wb_waddr_o      (wb_waddr),
    .ex_ready_o      (ex_ready_o),
    .ex_valid_o      (ex_valid_o)
  );

  ex_wb_ports u_wb_ports (
    .res                    (res_if.consumer),
    .regfile_alu_we_i       (regfile_alu_we_i),
    .regfile_alu_waddr_i    (regfile_alu_waddr_i),
    .csr_access_i           (csr_access_i),
    .csr_rdata_i            (csr_rdata_i),
    .wb_we_i                (wb_we),
    .wb_waddr_i             (wb_waddr),
    .lsu_rdata_i            (lsu_rdata_i),
    .regfile_alu_we_fw_o    (regfile_alu_we_fw_o),
    .regfile_alu_waddr_fw_o (regfile_alu_waddr_fw_o),
    .regfile_alu_wdata_fw_o (regfile_alu_wdata_fw_o),
    .regfile_we_wb_o        (regfile_we_wb_o),
    .regfile_waddr_wb_o     (regfile_waddr_wb_o),
    .regfile_wdata_wb_o     (regfile_wdata_wb_o),
    .branch_decision_o      (branch_decision_o)
  );

  // fault status straight off the voter
  assign err_detected_o     = res_if.err_detected;
  assign err_corrected_o    = res_if.err_corrected;
  assign permanent_faulty_o = res_if.faulty_lanes;

endmodule

`default_nettype wire

// ==== tb/tb_ex_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ex_cfg.svh"

module tb_ex_stage import ex_dp_pkg::*; import ex_ft_pkg::*; ();

  localparam int    CLK_PERIOD  = 4;
  localparam int    RST_CYCLES  = 4;
  // sample one ns ahead of the next rising edge
  localparam int    SAMPLE_DLY  = CLK_PERIOD - 1;
  localparam int    NUM_LANES   = `EX_NUM_LANES;
  localparam int    NUM_FIELDS  = 22;
  localparam string GOLDEN_FILE = "tb/ex_golden.txt";

  // dut pins carry the port names of the stage
  logic                    clk;
  logic                    rst_n;
  alu_op_e [NUM_LANES-1:0] alu_operator_i;
  data_t   [NUM_LANES-1:0] alu_operand_a_i;
  data_t   [NUM_LANES-1:0] alu_operand_b_i;
  logic                    alu_en_i;
  logic                    csr_access_i;
  data_t                   csr_rdata_i;
  logic                    lsu_en_i;
  data_t                   lsu_rdata_i;
  logic                    lsu_ready_ex_i;
  logic                    lsu_err_i;
  logic                    branch_in_ex_i;
  logic                    wb_ready_i;
  logic                    regfile_alu_we_i;
  regaddr_t                regfile_alu_waddr_i;
  logic                    regfile_we_i;
  regaddr_t                regfile_waddr_i;
  logic                    regfile_alu_we_fw_o;
  regaddr_t                regfile_alu_waddr_fw_o;
  data_t                   regfile_alu_wdata_fw_o;
  logic                    regfile_we_wb_o;
  regaddr_t                regfile_waddr_wb_o;
  data_t                   regfile_wdata_wb_o;
  logic                    branch_decision_o;
  logic                    ex_ready_o;
  logic                    ex_valid_o;
  logic                    err_detected_o;
  logic                    err_corrected_o;
  lane_mask_t              permanent_faulty_o;

  string vectors[$];
  int    errors;
  logic  loaded;

  ex_stage_top UUT (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  //////////////////////////////
  // compare tasks
  //////////////////////////////

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (act !== exp) begin
      $display("** Error %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_addr(input string name, input regaddr_t exp, input regaddr_t act);
    if (act !== exp) begin
      $display("** Error %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("** Error %s: expected %b, actual %b", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_lanes(input string name, input lane_mask_t exp, input lane_mask_t act);
    if (act !== exp) begin
      $display("** Error %s: expected %b, actual %b", name, exp, act);
      errors++;
    end
  endtask

  //////////////////////////////
  // golden file
  //////////////////////////////

  task automatic load_vectors();
    int    fd;
    string line;
    fd = $fopen(GOLDEN_FILE, "r");
    if (fd == 0) begin
      $display("could not open the golden file %s", GOLDEN_FILE);
      errors++;
    end else begin
      while ($fgets(line, fd) != 0) begin
        // comment lines and blank lines carry no vector
        if (line.len() > 1 && line.substr(0, 0) != "#") begin
          vectors.push_back(line);
        end
      end
      $fclose(fd);
      if (vectors.size() == 0) begin
        $display("the golden file holds no vectors");
        errors++;
      end
    end
  endtask

  // drive one line on the edge and check it just before the next one
  task automatic run_vector(input string line, input int idx);
    logic [3:0] op [NUM_LANES];
    data_t      a [NUM_LANES];
    data_t      b [NUM_LANES];
    logic [8:0] ctrl;
    data_t      csr;
    data_t      lrd;
    regaddr_t   waddr;
    data_t      e_fw;
    logic       e_br;
    logic       e_det;
    logic       e_corr;
    lane_mask_t e_fl;
    logic       e_we;
    regaddr_t   e_waddr;
    logic       e_valid;
    logic       e_ready;
    int         n;
    string      tag;
    n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %b %h %h %h %h %b %b %b %b %b %h %b %b",
                op[0], a[0], b[0], op[1], a[1], b[1], op[2], a[2], b[2], ctrl, csr, lrd,
                waddr, e_fw, e_br, e_det, e_corr, e_fl, e_we, e_waddr, e_valid, e_ready);
    if (n != NUM_FIELDS) begin
      $display("golden vector %0d is malformed, only %0d of %0d fields read", idx, n,
               NUM_FIELDS);
      errors++;
    end else begin
      @(posedge clk);
      for (int l = 0; l < NUM_LANES; l++) begin
        alu_operator_i[l]  <= alu_op_e'(op[l]);
        alu_operand_a_i[l] <= a[l];
        alu_operand_b_i[l] <= b[l];
      end
      // ctrl bits from msb down are lsu_err regfile_we alu_we branch wb_ready
      // lsu_ready lsu_en csr alu_en
      lsu_err_i           <= ctrl[8];
      regfile_we_i        <= ctrl[7];
      regfile_alu_we_i    <= ctrl[6];
      branch_in_ex_i      <= ctrl[5];
      wb_ready_i          <= ctrl[4];
      lsu_ready_ex_i      <= ctrl[3];
      lsu_en_i            <= ctrl[2];
      csr_access_i        <= ctrl[1];
      alu_en_i            <= ctrl[0];
      csr_rdata_i         <= csr;
      lsu_rdata_i         <= lrd;
      regfile_waddr_i     <= waddr;
      // forwarding port gets the complemented address to keep both ports apart
      regfile_alu_waddr_i <= ~waddr;
      #(SAMPLE_DLY);
      tag = $sformatf("vector %0d", idx);
      // forwarding port passes we and address straight through
      check_data({tag, " alu_wdata"}, e_fw, regfile_alu_wdata_fw_o);
      check_flag({tag, " alu_we"}, ctrl[6], regfile_alu_we_fw_o);
      check_addr({tag, " alu_waddr"}, ~waddr, regfile_alu_waddr_fw_o);
      check_flag({tag, " branch"}, e_br, branch_decision_o);
      check_flag({tag, " err_detected"}, e_det, err_detected_o);
      check_flag({tag, " err_corrected"}, e_corr, err_corrected_o);
      check_lanes({tag, " faulty_lanes"}, e_fl, permanent_faulty_o);
      // write-back columns refer to the line before
      check_flag({tag, " wb_we"}, e_we, regfile_we_wb_o);
      if (e_we) begin
        check_addr({tag, " wb_waddr"}, e_waddr, regfile_waddr_wb_o);
        check_data({tag, " wb_wdata"}, lrd, regfile_wdata_wb_o);
      end
      check_flag({tag, " ex_valid"}, e_valid, ex_valid_o);
      check_flag({tag, " ex_ready"}, e_ready, ex_ready_o);
    end
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin
    errors = 0;
    loaded = 1'b0;
    rst_n  <= 1'b0;
    for (int l = 0; l < NUM_LANES; l++) begin
      alu_operator_i[l]  <= ALU_ADD;
      alu_operand_a_i[l] <= '0;
      alu_operand_b_i[l] <= '0;
    end
    alu_en_i            <= 1'b0;
    csr_access_i        <= 1'b0;
    csr_rdata_i         <= '0;
    lsu_en_i            <= 1'b0;
    lsu_rdata_i         <= '0;
    lsu_ready_ex_i      <= 1'b0;
    lsu_err_i           <= 1'b0;
    branch_in_ex_i      <= 1'b0;
    wb_ready_i          <= 1'b0;
    regfile_alu_we_i    <= 1'b0;
    regfile_alu_waddr_i <= '0;
    regfile_we_i        <= 1'b0;
    regfile_waddr_i     <= '0;
    load_vectors();
    loaded = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    for (int i = 0; i < vectors.size(); i++) begin
      run_vector(vectors[i], i);
    end
    $display("vectors run: %0d, errors: %0d", vectors.size(), errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // watchdog allows four times the nominal run length plus reset
  initial begin
    int limit_ns;
    wait (loaded);
    limit_ns = vectors.size() * CLK_PERIOD * 4 + RST_CYCLES * CLK_PERIOD;
    #(limit_ns);
    $display("timeout after %0d ns, the vector run did not complete", limit_ns);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+source
source/ex_dp_pkg.sv
source/ex_ft_pkg.sv
source/alu_result_if.sv
source/ex_alu_lane.sv
source/ex_tmr_voter.sv
source/ex_wb_reg.sv
source/ex_wb_ports.sv
source/ex_stage_top.sv
tb/tb_ex_stage.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the ex stage testbench with verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing -f files.f --top-module tb_ex_stage -o tb_ex_stage \
  > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }

./obj_dir/tb_ex_stage 2>&1 | tee sim.log

grep -qx "NO ERRORS" sim.log && echo "PASS" && exit 0 || { echo "FAIL, see sim.log"; exit 1; }

// ==== tb/ex_golden.txt ====
# per lane op a b (hex), ctrl bits msb first: lsu_err regfile_we alu_we branch wb_ready lsu_ready lsu_en csr alu_en
# then csr_rdata lsu_rdata waddr, expected: alu_wdata branch det corr faulty wb_we wb_waddr valid ready
0 5 3 0 5 3 0 5 3 001011001 0 0 01 8 0 0 0 000 0 0 1 1
1 3 5 1 3 5 1 3 5 001011001 0 0 02 fffffffe 0 0 0 000 0 0 1 1
2 f0f0 ff00 2 f0f0 ff00 2 f0f0 ff00 001011001 0 0 03 f000 0 0 0 000 0 0 1 1
3 f0f0 0f0f 3 f0f0 0f0f 3 f0f0 0f0f 001011001 0 0 04 ffff 0 0 0 000 0 0 1 1
4 ff00 0ff0 4 ff00 0ff0 4 ff00 0ff0 001011001 0 0 05 f0f0 0 0 0 000 0 0 1 1
5 1 24 5 1 24 5 1 24 001011001 0 0 06 10 0 0 0 000 0 0 1 1
6 80000000 1f 6 80000000 1f 6 80000000 1f 001011001 0 0 07 1 0 0 0 000 0 0 1 1
7 3 ffffffff 7 3 ffffffff 7 3 ffffffff 001011001 0 0 08 1 1 0 0 000 0 0 1 1
8 7 7 8 7 7 8 7 7 001011001 0 0 09 1 1 0 0 000 0 0 1 1
8 7 8 8 7 8 8 7 8 001011001 0 0 0a 0 0 0 0 000 0 0 1 1
0 1 1 0 1 1 0 1 1 001011011 cafe 0 0b cafe 0 0 0 000 0 0 1 1
0 1 1 0 1 2 0 1 3 001011001 0 0 0c 2 0 1 0 000 0 0 1 1
0 5 4 0 4 4 0 4 4 001011001 0 0 0d 8 0 1 1 000 0 0 1 1
0 4 4 0 4 5 0 4 4 001011001 0 0 0e 8 0 1 1 000 0 0 1 1
0 10 20 0 10 20 0 11 20 001011000 0 0 0f 30 0 0 0 000 0 0 0 1
0 10 20 0 10 20 0 11 20 001011001 0 0 10 30 0 1 1 000 0 0 1 1
1 100 1 1 100 1 1 100 2 001011001 0 0 11 ff 0 1 1 000 0 0 1 1
4 aa 55 4 aa 55 4 ab 55 001011001 0 0 12 ff 0 1 1 000 0 0 1 1
3 1 2 3 1 2 3 1 6 001011001 0 0 13 3 0 1 1 000 0 0 1 1
0 2 2 0 2 2 0 2 2 001011001 0 0 14 4 0 0 0 100 0 0 1 1
0 2 2 0 2 2 0 9 2 001011001 0 0 15 4 0 0 0 100 0 0 1 1
0 6 1 0 8 1 0 6 1 001011001 0 0 16 7 0 1 0 100 0 0 1 1
0 0 0 0 0 0 0 0 0 010011100 0 1234 15 0 0 0 0 100 0 0 1 1
0 0 0 0 0 0 0 0 0 000001001 0 1234 00 0 0 0 0 100 1 15 0 0
0 0 0 0 0 0 0 0 0 000101001 0 1234 00 0 0 0 0 100 1 15 0 1
0 0 0 0 0 0 0 0 0 000010000 0 1234 00 0 0 0 0 100 1 15 0 0
0 0 0 0 0 0 0 0 0 110011100 0 5678 2a 0 0 0 0 100 0 0 1 1
0 0 0 0 0 0 0 0 0 001011001 0 0 01 0 0 0 0 100 0 0 1 1
